// ==== run_sim.sh ====
#!/bin/sh
# compile and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module datapath_tb -o datapath_sim
out=$(./obj_dir/datapath_sim 2>&1) || true
echo "$out"
echo "$out" | grep -qx "Verification passed"

// ==== sim/datapath_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dp_settings.svh"

module datapath_asserts (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  cmd_valid,
  input logic                  cmd_ready,
  input logic [`DP_ADDR_W-1:0] rs1,
  input logic [`DP_ADDR_W-1:0] rs2,
  input logic [`DP_ADDR_W-1:0] rd,
  input logic                  imm_reg_select,
  input logic                  wb_en,
  input logic                  res_valid,
  input logic                  res_ready,
  input logic [`DP_ADDR_W-1:0] res_rd,
  input logic [`DP_DATA_W-1:0] res_data,
  input logic                  res_overflow,
  input logic                  res_wb_en
);

  logic [`DP_NUM_REGS-1:0] busy_q;
  logic [`DP_NUM_REGS-1:0] busy_now;
  logic                    src_busy;

  // pending writes as seen from the ports
  always_comb begin
    busy_now = busy_q;
    if (res_valid && res_ready && res_wb_en) busy_now[res_rd] = 1'b0;
  end

  assign src_busy = busy_now[rs1] || (!imm_reg_select && busy_now[rs2]);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_now;
      if (cmd_valid && cmd_ready && wb_en) busy_q[rd] <= 1'b1;
    end
  end

  a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid && !res_ready |=>
      res_valid && $stable({res_rd, res_data, res_overflow, res_wb_en}))
    else $error("result payload changed while res_ready was low");

  a_reset_idle: assert property (@(posedge clk) !rst_n |=> !res_valid)
    else $error("res_valid high after reset");

  a_stall_busy: assert property (@(posedge clk) disable iff (!rst_n)
    src_busy |-> !cmd_ready)
    else $error("cmd_ready high while a source register is busy");

endmodule

bind datapath_top datapath_asserts u_asserts (
  .clk(clk), .rst_n(rst_n),
  .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
  .rs1(rs1), .rs2(rs2), .rd(rd),
  .imm_reg_select(imm_reg_select), .wb_en(wb_en),
  .res_valid(res_valid), .res_ready(res_ready),
  .res_rd(res_rd), .res_data(res_data),
  .res_overflow(res_overflow), .res_wb_en(res_wb_en)
);

`default_nettype wire

// ==== sim/datapath_cases.txt ====
# rs1 rs2 rd imm5 imm15 imm20 imm_sel imm_reg_sel wb_sel wb_en opcode sub_opcode
# then expected res_rd res_data res_overflow, all hex
00 00 01 1f 0000 00000 0 1 1 1 00 00 01 0000001f 0
00 00 02 00 4000 00000 1 1 1 1 00 00 02 ffffc000 0
00 00 03 00 7abc 00000 2 1 1 1 00 00 03 00007abc 0
00 00 04 00 0000 80001 3 1 1 1 00 00 04 fff80001 0
00 00 05 00 0000 fffff 3 1 1 1 00 00 05 ffffffff 0
00 00 06 01 0000 00000 0 1 1 1 00 00 06 00000001 0
05 06 07 00 0000 00000 0 0 0 1 00 09 07 7fffffff 0
07 06 08 00 0000 00000 0 0 0 1 00 00 08 80000000 1
08 06 09 00 0000 00000 0 0 0 1 00 01 09 7fffffff 1
07 05 0a 00 0000 00000 0 0 0 1 00 01 0a 80000000 1
05 06 0b 00 0000 00000 0 0 0 1 00 00 0b 00000000 0
02 03 0c 00 0000 00000 0 0 0 1 00 02 0c 00004000 0
01 03 0d 00 0000 00000 0 0 0 1 00 03 0d 00007abf 0
02 03 0e 00 0000 00000 0 0 0 1 00 05 0e 00000543 0
04 01 0f 00 0000 00000 0 0 0 1 00 04 0f fff8001e 0
04 01 10 00 0000 00000 0 0 0 1 00 06 10 00000001 0
04 01 11 00 0000 00000 0 0 0 1 00 07 11 00000000 0
06 01 12 00 0000 00000 0 0 0 1 00 08 12 80000000 0
04 06 13 00 0000 00000 0 0 0 1 00 0a 13 fffc0000 0
03 01 14 00 0000 00000 0 0 0 1 00 0b 14 0000f578 0
01 03 15 00 0000 00000 0 0 0 1 00 1c 15 00000000 0
01 06 01 00 0000 00000 0 0 0 0 00 00 01 00000020 0
00 01 16 00 0000 00000 0 0 1 1 00 00 16 0000001f 0
00 03 17 00 0000 00000 0 0 0 1 23 00 17 00007abc 0

// ==== sim/datapath_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dp_settings.svh"

module datapath_tb;

  localparam int MAX_CASES  = 64;
  localparam int NUM_COLS   = 15;
  localparam int WAIT_LIMIT = 200;

  logic                  clk;
  logic                  rst_n;
  logic                  cmd_valid;
  logic                  cmd_ready;
  logic [`DP_ADDR_W-1:0] rs1;
  logic [`DP_ADDR_W-1:0] rs2;
  logic [`DP_ADDR_W-1:0] rd;
  logic [4:0]            imm_5bit;
  logic [14:0]           imm_15bit;
  logic [19:0]           imm_20bit;
  logic [1:0]            imm_sel;
  logic                  imm_reg_select;
  logic                  wb_select;
  logic                  wb_en;
  logic [`DP_OPC_W-1:0]  opcode;
  logic [`DP_SUB_W-1:0]  sub_opcode;
  logic                  res_valid;
  logic                  res_ready;
  logic [`DP_ADDR_W-1:0] res_rd;
  logic [`DP_DATA_W-1:0] res_data;
  logic                  res_overflow;
  logic                  res_wb_en;

  // one row per command, columns in cases file order
  logic [31:0] case_col [MAX_CASES][NUM_COLS];
  int          num_cases;
  int          data_errs;
  int          timeout_errs;
  int          other_errs;
  logic [31:0] lcg_state = 32'hadae_f023;

  datapath_top dut (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic load_cases();
    int    fd;
    int    got;
    string line;
    fd = $fopen("sim/datapath_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the cases file sim/datapath_cases.txt");
      other_errs++;
      return;
    end
    while (!$feof(fd) && num_cases < MAX_CASES) begin
      line = "";
      got  = $fgets(line, fd);
      if (got > 1 && line.getc(0) != "#") begin // skip comments and blank lines
        got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      case_col[num_cases][0], case_col[num_cases][1],
                      case_col[num_cases][2], case_col[num_cases][3],
                      case_col[num_cases][4], case_col[num_cases][5],
                      case_col[num_cases][6], case_col[num_cases][7],
                      case_col[num_cases][8], case_col[num_cases][9],
                      case_col[num_cases][10], case_col[num_cases][11],
                      case_col[num_cases][12], case_col[num_cases][13],
                      case_col[num_cases][14]);
        if (got == NUM_COLS) begin
          num_cases++;
        end else begin
          $display("malformed line in the cases file: %s", line);
          other_errs++;
        end
      end
    end
    $fclose(fd);
    if (num_cases == 0) begin
      $display("the cases file holds no commands");
      other_errs++;
    end
  endtask

  task automatic drive_commands();
    int   wait_cnt;
    logic accepted;
    for (int i = 0; i < num_cases; i++) begin
      cmd_valid      <= 1'b1;
      rs1            <= case_col[i][0][`DP_ADDR_W-1:0];
      rs2            <= case_col[i][1][`DP_ADDR_W-1:0];
      rd             <= case_col[i][2][`DP_ADDR_W-1:0];
      imm_5bit       <= case_col[i][3][4:0];
      imm_15bit      <= case_col[i][4][14:0];
      imm_20bit      <= case_col[i][5][19:0];
      imm_sel        <= case_col[i][6][1:0];
      imm_reg_select <= case_col[i][7][0];
      wb_select      <= case_col[i][8][0];
      wb_en          <= case_col[i][9][0];
      opcode         <= case_col[i][10][`DP_OPC_W-1:0];
      sub_opcode     <= case_col[i][11][`DP_SUB_W-1:0];
      wait_cnt = 0;
      accepted = 1'b0;
      while (!accepted && wait_cnt < WAIT_LIMIT) begin
        @(negedge clk);
        accepted = cmd_ready; // transfer happens at the coming edge
        @(posedge clk);
        wait_cnt++;
      end
      if (!accepted) begin
        $display("timeout: cmd_valid/cmd_ready handshake stalled on case %0d", i);
        timeout_errs++;
        cmd_valid <= 1'b0;
        return;
      end
    end
    cmd_valid <= 1'b0;
  endtask

  task automatic compare_result(input int idx);
    if (res_rd !== case_col[idx][12][`DP_ADDR_W-1:0]) begin
      $display("ERROR case %0d: res_rd got %h expected %h",
               idx, res_rd, case_col[idx][12][`DP_ADDR_W-1:0]);
      data_errs++;
    end
    if (res_data !== case_col[idx][13]) begin
      $display("ERROR case %0d: res_data got %h expected %h",
               idx, res_data, case_col[idx][13]);
      data_errs++;
    end
    if (res_overflow !== case_col[idx][14][0]) begin
      $display("ERROR case %0d: res_overflow got %h expected %h",
               idx, res_overflow, case_col[idx][14][0]);
      data_errs++;
    end
    if (res_wb_en !== case_col[idx][9][0]) begin
      $display("ERROR case %0d: res_wb_en got %h expected %h",
               idx, res_wb_en, case_col[idx][9][0]);
      data_errs++;
    end
  endtask

  task automatic check_results();
    int   wait_cnt;
    logic seen;
    for (int i = 0; i < num_cases; i++) begin
      wait_cnt = 0;
      seen     = 1'b0;
      while (!seen && wait_cnt < WAIT_LIMIT) begin
        @(negedge clk);
        seen = res_valid && res_ready;
        wait_cnt++;
      end
      if (!seen) begin
        $display("timeout: no result on res_valid/res_ready for case %0d", i);
        timeout_errs++;
        return;
      end
      compare_result(i);
    end
    // results must not repeat after the last one
    repeat (10) begin
      @(negedge clk);
      if (res_valid && res_ready) begin
        $display("an extra result arrived after the last command, res_rd %h", res_rd);
        other_errs++;
      end
    end
  endtask

  task automatic report_and_finish();
    $display("errors: data %0d, timeout %0d, other %0d",
             data_errs, timeout_errs, other_errs);
    if (data_errs + timeout_errs + other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  // sink stalls about one cycle in four
  initial begin : drive_res_ready
    logic [31:0] rnd;
    res_ready = 1'b0;
    forever begin
      @(posedge clk);
      rnd = next_random();
      res_ready <= (rnd[31:30] != 2'b00);
    end
  end

  initial begin
    rst_n          = 1'b0;
    cmd_valid      = 1'b0;
    rs1            = '0;
    rs2            = '0;
    rd             = '0;
    imm_5bit       = '0;
    imm_15bit      = '0;
    imm_20bit      = '0;
    imm_sel        = '0;
    imm_reg_select = 1'b0;
    wb_select      = 1'b0;
    wb_en          = 1'b0;
    opcode         = '0;
    sub_opcode     = '0;
    num_cases      = 0;
    data_errs      = 0;
    timeout_errs   = 0;
    other_errs     = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    load_cases();
    if (num_cases > 0) begin
      fork
        drive_commands();
        check_results();
      join
    end
    report_and_finish();
  end

endmodule

`default_nettype wire

// ==== source/alu32.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dp_settings.svh"

module alu32
  import dp_pkg::*;
(
  input  logic        ex_valid,
  output logic        ex_ready,
  input  ex_payload_t ex_payload,
  output logic        wb_valid,
  input  logic        wb_ready,
  output wb_payload_t wb_payload
);

  logic [`DP_DATA_W-1:0]   a;
  logic [`DP_DATA_W-1:0]   b;
  logic [4:0]              shamt;
  logic [`DP_DATA_W-1:0]   sum;
  logic [`DP_DATA_W-1:0]   diff;
  logic [2*`DP_DATA_W-1:0] rot_full;
  logic [`DP_DATA_W-1:0]   alu_result;
  logic                    alu_ovf;

  // handshake passes straight through
  assign wb_valid = ex_valid;
  assign ex_ready = wb_ready;

  assign a        = ex_payload.src1;
  assign b        = ex_payload.src2;
  assign shamt    = b[4:0];
  assign sum      = a + b;
  assign diff     = a - b;
  assign rot_full = {a, a} >> shamt;

  always_comb begin
    alu_result = '0; // unknown sub-opcode gives zero
    alu_ovf    = 1'b0;
    if (ex_payload.opcode != ALU_OPCODE) begin
      alu_result = b; // non-alu class passes operand
    end else begin
      case (ex_payload.sub_opcode)
        alu_add: begin
          alu_result = sum;
          alu_ovf    = (a[`DP_DATA_W-1] == b[`DP_DATA_W-1]) &&
                       (sum[`DP_DATA_W-1] != a[`DP_DATA_W-1]);
        end
        alu_sub: begin
          alu_result = diff;
          alu_ovf    = (a[`DP_DATA_W-1] != b[`DP_DATA_W-1]) &&
                       (diff[`DP_DATA_W-1] != a[`DP_DATA_W-1]);
        end
        alu_and:  alu_result = a & b;
        alu_or:   alu_result = a | b;
        alu_xor:  alu_result = a ^ b;
        alu_nor:  alu_result = ~(a | b);
        alu_slt:  alu_result = {{(`DP_DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
        alu_sltu: alu_result = {{(`DP_DATA_W-1){1'b0}}, a < b};
        alu_sll:  alu_result = a << shamt;
        alu_srl:  alu_result = a >> shamt;
        alu_sra:  alu_result = $signed(a) >>> shamt;
        alu_rotr: alu_result = rot_full[`DP_DATA_W-1:0];
        default:  alu_result = '0;
      endcase
    end
  end

  // overflow only means something when the alu result is written
  always_comb begin
    wb_payload.result   = ex_payload.wb_select ? b : alu_result;
    wb_payload.overflow = alu_ovf & !ex_payload.wb_select;
    wb_payload.wb_en    = ex_payload.wb_en;
    wb_payload.rd       = ex_payload.rd;
  end

endmodule

`default_nettype wire

// ==== source/datapath_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dp_settings.svh"

module datapath_top
  import dp_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  logic [`DP_ADDR_W-1:0] rs1,
  input  logic [`DP_ADDR_W-1:0] rs2,
  input  logic [`DP_ADDR_W-1:0] rd,
  input  logic [4:0]            imm_5bit,
  input  logic [14:0]           imm_15bit,
  input  logic [19:0]           imm_20bit,
  input  logic [1:0]            imm_sel,
  input  logic                  imm_reg_select,
  input  logic                  wb_select,
  input  logic                  wb_en,
  input  logic [`DP_OPC_W-1:0]  opcode,
  input  logic [`DP_SUB_W-1:0]  sub_opcode,
  output logic                  res_valid,
  input  logic                  res_ready,
  output logic [`DP_ADDR_W-1:0] res_rd,
  output logic [`DP_DATA_W-1:0] res_data,
  output logic                  res_overflow,
  output logic                  res_wb_en
);

  logic [`DP_ADDR_W-1:0] rd_addr1;
  logic [`DP_ADDR_W-1:0] rd_addr2;
  logic [`DP_DATA_W-1:0] rd_data1;
  logic [`DP_DATA_W-1:0] rd_data2;
  logic                  ex_in_valid;
  logic                  ex_in_ready;
  ex_payload_t           ex_in_data;
  logic                  ex_out_valid;
  logic                  ex_out_ready;
  ex_payload_t           ex_out_data;
  logic                  wb_in_valid;
  logic                  wb_in_ready;
  wb_payload_t           wb_in_data;
  wb_payload_t           wb_out_data;
  logic                  wb_fire;

  assign wb_fire = res_valid & res_ready & res_wb_en; // register write this edge

  operand_stage u_operand_stage (
    .clk(clk), .rst_n(rst_n),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .rs1(rs1), .rs2(rs2), .rd(rd),
    .imm_5bit(imm_5bit), .imm_15bit(imm_15bit), .imm_20bit(imm_20bit),
    .imm_sel(imm_sel), .imm_reg_select(imm_reg_select),
    .wb_select(wb_select), .wb_en(wb_en),
    .opcode(opcode), .sub_opcode(sub_opcode),
    .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
    .rd_data1(rd_data1), .rd_data2(rd_data2),
    .ex_valid(ex_in_valid), .ex_payload(ex_in_data), .ex_ready(ex_in_ready),
    .wb_fire(wb_fire), .wb_addr(res_rd)
  );

  stage_reg #(.payload_t(ex_payload_t)) ex_stage (
    .clk(clk), .rst_n(rst_n),
    .in_valid(ex_in_valid), .in_ready(ex_in_ready), .in_data(ex_in_data),
    .out_valid(ex_out_valid), .out_ready(ex_out_ready), .out_data(ex_out_data)
  );

  alu32 u_alu32 (
    .ex_valid(ex_out_valid), .ex_ready(ex_out_ready), .ex_payload(ex_out_data),
    .wb_valid(wb_in_valid), .wb_ready(wb_in_ready), .wb_payload(wb_in_data)
  );

  stage_reg #(.payload_t(wb_payload_t)) wb_stage (
    .clk(clk), .rst_n(rst_n),
    .in_valid(wb_in_valid), .in_ready(wb_in_ready), .in_data(wb_in_data),
    .out_valid(res_valid), .out_ready(res_ready), .out_data(wb_out_data)
  );

  regfile u_regfile (
    .clk(clk), .rst_n(rst_n),
    .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
    .wr_en(wb_fire), .wr_addr(res_rd), .wr_data(res_data),
    .rd_data1(rd_data1), .rd_data2(rd_data2)
  );

  assign res_rd       = wb_out_data.rd;
  assign res_data     = wb_out_data.result;
  assign res_overflow = wb_out_data.overflow;
  assign res_wb_en    = wb_out_data.wb_en;

endmodule

`default_nettype wire

// ==== source/dp_pkg.sv ====
`default_nettype none

`include "dp_settings.svh"

package dp_pkg;

  typedef enum logic [1:0] {
    imm5_ze  = 2'b00,
    imm15_se = 2'b01,
    imm15_ze = 2'b10,
    imm20_se = 2'b11
  } imm_sel_t;

  typedef enum logic [`DP_SUB_W-1:0] {
    alu_add  = 5'h00,
    alu_sub  = 5'h01,
    alu_and  = 5'h02,
    alu_or   = 5'h03,
    alu_xor  = 5'h04,
    alu_nor  = 5'h05,
    alu_slt  = 5'h06, // signed compare
    alu_sltu = 5'h07,
    alu_sll  = 5'h08,
    alu_srl  = 5'h09,
    alu_sra  = 5'h0a,
    alu_rotr = 5'h0b
  } alu_sub_t;

  localparam logic [`DP_OPC_W-1:0] ALU_OPCODE = 6'b000000; // alu class

  typedef struct packed {
    logic [`DP_DATA_W-1:0] src1;
    logic [`DP_DATA_W-1:0] src2;
    logic [`DP_OPC_W-1:0]  opcode;
    alu_sub_t              sub_opcode;
    logic                  wb_select; // 1 = write operand, 0 = alu result
    logic                  wb_en;
    logic [`DP_ADDR_W-1:0] rd;
  } ex_payload_t;

  typedef struct packed {
    logic [`DP_DATA_W-1:0] result;
    logic                  overflow;
    logic                  wb_en;
    logic [`DP_ADDR_W-1:0] rd;
  } wb_payload_t;

endpackage

`default_nettype wire

// ==== source/dp_settings.svh ====
`ifndef DP_SETTINGS_SVH
`define DP_SETTINGS_SVH

// datapath word width
`define DP_DATA_W 32

// register address width
`define DP_ADDR_W 5

// number of registers in the file
`define DP_NUM_REGS 32

// opcode field width
`define DP_OPC_W 6

// sub-opcode field width
`define DP_SUB_W 5

`endif

// ==== source/operand_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dp_settings.svh"

module operand_stage
  import dp_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  logic [`DP_ADDR_W-1:0] rs1,
  input  logic [`DP_ADDR_W-1:0] rs2,
  input  logic [`DP_ADDR_W-1:0] rd,
  input  logic [4:0]            imm_5bit,
  input  logic [14:0]           imm_15bit,
  input  logic [19:0]           imm_20bit,
  input  logic [1:0]            imm_sel,
  input  logic                  imm_reg_select,
  input  logic                  wb_select,
  input  logic                  wb_en,
  input  logic [`DP_OPC_W-1:0]  opcode,
  input  logic [`DP_SUB_W-1:0]  sub_opcode,
  output logic [`DP_ADDR_W-1:0] rd_addr1,
  output logic [`DP_ADDR_W-1:0] rd_addr2,
  input  logic [`DP_DATA_W-1:0] rd_data1,
  input  logic [`DP_DATA_W-1:0] rd_data2,
  output logic                  ex_valid,
  output ex_payload_t           ex_payload,
  input  logic                  ex_ready,
  input  logic                  wb_fire,
  input  logic [`DP_ADDR_W-1:0] wb_addr
);

  logic [`DP_DATA_W-1:0]   imm_ext;
  logic [`DP_NUM_REGS-1:0] busy;
  logic [`DP_NUM_REGS-1:0] busy_live;
  logic                    hazard;
  logic                    accept;

  assign rd_addr1 = rs1;
  assign rd_addr2 = rs2;

  always_comb begin
    case (imm_sel_t'(imm_sel))
      imm5_ze:  imm_ext = {{(`DP_DATA_W-5){1'b0}}, imm_5bit};
      imm15_se: imm_ext = {{(`DP_DATA_W-15){imm_15bit[14]}}, imm_15bit};
      imm15_ze: imm_ext = {{(`DP_DATA_W-15){1'b0}}, imm_15bit};
      imm20_se: imm_ext = {{(`DP_DATA_W-20){imm_20bit[19]}}, imm_20bit};
      default:  imm_ext = '0;
    endcase
  end

  // a retiring result frees its register this cycle
  always_comb begin
    busy_live = busy;
    if (wb_fire) busy_live[wb_addr] = 1'b0;
  end

  // rd is also checked so two writes to one register never overlap
  assign hazard = busy_live[rs1] | (!imm_reg_select & busy_live[rs2]) |
                  (wb_en & busy_live[rd]);

  assign cmd_ready = ex_ready & !hazard;
  assign ex_valid  = cmd_valid & !hazard;
  assign accept    = cmd_valid & cmd_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= '0;
    end else begin
      busy <= busy_live;
      if (accept && wb_en) busy[rd] <= 1'b1; // set wins over clear
    end
  end

  always_comb begin
    ex_payload.src1       = rd_data1;
    ex_payload.src2       = imm_reg_select ? imm_ext : rd_data2;
    ex_payload.opcode     = opcode;
    ex_payload.sub_opcode = alu_sub_t'(sub_opcode);
    ex_payload.wb_select  = wb_select;
    ex_payload.wb_en      = wb_en;
    ex_payload.rd         = rd;
  end

endmodule

`default_nettype wire

// ==== source/regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dp_settings.svh"

module regfile (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`DP_ADDR_W-1:0] rd_addr1,
  input  logic [`DP_ADDR_W-1:0] rd_addr2,
  input  logic                  wr_en,
  input  logic [`DP_ADDR_W-1:0] wr_addr,
  input  logic [`DP_DATA_W-1:0] wr_data,
  output logic [`DP_DATA_W-1:0] rd_data1,
  output logic [`DP_DATA_W-1:0] rd_data2
);

  logic [`DP_DATA_W-1:0] regs [`DP_NUM_REGS];
  logic                  hit1;
  logic                  hit2;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `DP_NUM_REGS; i++) begin
        regs[i] <= '0; // all registers read zero after reset
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // same-cycle write is visible on the read ports
  assign hit1 = wr_en && (wr_addr == rd_addr1);
  assign hit2 = wr_en && (wr_addr == rd_addr2);

  assign rd_data1 = hit1 ? wr_data : regs[rd_addr1];
  assign rd_data2 = hit2 ? wr_data : regs[rd_addr2];

endmodule

`default_nettype wire

// ==== source/stage_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     full;
  payload_t data_q;
  logic     load;

  // refill while the current entry drains
  assign in_ready = !full || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) data_q <= in_data;
  end

  assign out_valid = full;
  assign out_data  = data_q;

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/dp_pkg.sv
source/regfile.sv
source/operand_stage.sv
source/stage_reg.sv
source/alu32.sv
source/datapath_top.sv
sim/datapath_asserts.sv
sim/datapath_tb.sv
